// ==== verilog/init_pkg.sv ====
package init_pkg;

	// Sequencer states, also used as the code of the failing stage
	typedef enum logic [2:0] {
		STG_IDLE  = 3'd0,
		STG_CHECK = 3'd1,
		STG_LOAD  = 3'd2,
		STG_COMP  = 3'd3,
		STG_RD_ID = 3'd4
	} stage_e;

	// Single-cycle answer of one step
	typedef struct packed {
		logic done;
		logic error;
	} step_status_t;

	// Result record of a whole init run
	typedef struct packed {
		stage_e      fail_stage;
		logic [7:0]  img_len;
		logic [15:0] dev_id;
		logic [15:0] vendor_id;
	} init_status_t;

endpackage

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

	localparam int RAM_AW    = 6;
	localparam int RAM_DEPTH = 64;
	localparam int FLASH_AW  = 8;

	// Identification word sits in the top flash word
	localparam logic [FLASH_AW-1:0] ID_ADDR = 8'd255;

	localparam logic [15:0] IMG_MAGIC = 16'hB007;
	localparam logic [15:0] VENDOR_ID = 16'h1A5C;

	// Reflected CRC-32, preset to all ones, result inverted
	localparam logic [31:0] CRC_POLY = 32'hEDB88320;

	// Background pattern of the march test
	localparam logic [31:0] MARCH_PAT = 32'h55555555;

	typedef struct packed {
		logic              we;
		logic              re;
		logic [RAM_AW-1:0] addr;
		logic [31:0]       wdata;
	} ram_req_t;

	typedef struct packed {
		logic                rd;
		logic [FLASH_AW-1:0] addr;
	} flash_req_t;

	typedef struct packed {
		logic [15:0] magic;
		logic [7:0]  img_len;
		logic [7:0]  rsvd;
	} img_hdr_t;

	typedef struct packed {
		logic [15:0] vendor;
		logic [15:0] device;
	} ident_t;

	// Flash word 0 reads as a header, the ID word as an ident record
	typedef union packed {
		logic [31:0] raw;
		img_hdr_t    hdr;
		ident_t      ident;
	} boot_word_u;

endpackage

// ==== verilog/init_sequencer.sv ====
`timescale 1ns/1ps

module init_sequencer (
	input  logic                   sys_clk,
	input  logic                   glbl_rst_n,
	input  logic                   init_start,
	input  init_pkg::step_status_t check_st,
	input  init_pkg::step_status_t load_st,
	input  init_pkg::step_status_t comp_st,
	input  init_pkg::step_status_t id_st,
	input  logic [7:0]             img_len,
	input  mem_pkg::boot_word_u    id_word,
	output logic                   check_en,
	output logic                   load_en,
	output logic                   comp_en,
	output logic                   id_en,
	output logic                   init_ok,
	output logic                   init_fail,
	output init_pkg::init_status_t init_status
);

	init_pkg::stage_e       state;
	init_pkg::step_status_t cur_st;

	// Answer of the step that is running now
	always_comb
	begin
		case (state)
			init_pkg::STG_CHECK: cur_st = check_st;
			init_pkg::STG_LOAD:  cur_st = load_st;
			init_pkg::STG_COMP:  cur_st = comp_st;
			init_pkg::STG_RD_ID: cur_st = id_st;
			default:             cur_st = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state       <= init_pkg::STG_IDLE;
			check_en    <= 1'b0;
			load_en     <= 1'b0;
			comp_en     <= 1'b0;
			id_en       <= 1'b0;
			init_ok     <= 1'b0;
			init_fail   <= 1'b0;
			init_status <= '0;
		end
		else
		begin
			// Enables and results only ever pulse
			check_en  <= 1'b0;
			load_en   <= 1'b0;
			comp_en   <= 1'b0;
			id_en     <= 1'b0;
			init_ok   <= 1'b0;
			init_fail <= 1'b0;
			case (state)
				init_pkg::STG_IDLE:
				begin
					if (init_start)
					begin
						init_status <= '0;
						check_en    <= 1'b1;
						state       <= init_pkg::STG_CHECK;
					end
				end
				init_pkg::STG_CHECK, init_pkg::STG_LOAD, init_pkg::STG_COMP,
				init_pkg::STG_RD_ID:
				begin
					if (cur_st.error)
					begin
						init_fail              <= 1'b1;
						init_status.fail_stage <= state;
						state                  <= init_pkg::STG_IDLE;
					end
					else if (cur_st.done)
					begin
						case (state)
							init_pkg::STG_CHECK:
							begin
								load_en <= 1'b1;
								state   <= init_pkg::STG_LOAD;
							end
							init_pkg::STG_LOAD:
							begin
								comp_en <= 1'b1;
								state   <= init_pkg::STG_COMP;
							end
							init_pkg::STG_COMP:
							begin
								id_en <= 1'b1;
								state <= init_pkg::STG_RD_ID;
							end
							default:
							begin
								// ID read was the last step
								init_ok               <= 1'b1;
								init_status.img_len   <= img_len;
								init_status.dev_id    <= id_word.ident.device;
								init_status.vendor_id <= id_word.ident.vendor;
								state                 <= init_pkg::STG_IDLE;
							end
						endcase
					end
				end
				default: state <= init_pkg::STG_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/ram_march_checker.sv ====
`timescale 1ns/1ps

module ram_march_checker (
	input  logic                   sys_clk,
	input  logic                   glbl_rst_n,
	input  logic                   check_en,
	output mem_pkg::ram_req_t      ram_req,
	input  logic [31:0]            ram_rdata,
	output init_pkg::step_status_t check_st
);

	typedef enum logic [2:0] {M_IDLE, M_WR, M_RW, M_RD, M_END} march_e;

	march_e                     state;
	logic [mem_pkg::RAM_AW-1:0] addr;
	logic                       chk_q;
	logic [31:0]                exp_q;
	logic [31:0]                pat;

	// Address byte in all four lanes, over the 55 background
	assign pat = {4{8'(addr)}} ^ mem_pkg::MARCH_PAT;

	always_comb
	begin
		ram_req = '0;
		case (state)
			M_WR:
			begin
				ram_req.we    = 1'b1;
				ram_req.addr  = addr;
				ram_req.wdata = pat;
			end
			M_RW:
			begin
				// Read before write, old word comes back next cycle
				ram_req.we    = 1'b1;
				ram_req.re    = 1'b1;
				ram_req.addr  = addr;
				ram_req.wdata = ~pat;
			end
			M_RD:
			begin
				ram_req.re   = 1'b1;
				ram_req.addr = addr;
			end
			default: ram_req = '0;
		endcase
	end

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state    <= M_IDLE;
			addr     <= '0;
			chk_q    <= 1'b0;
			check_st <= '0;
		end
		else
		begin
			check_st <= '0;
			chk_q    <= 1'b0;
			case (state)
				M_IDLE:
				begin
					addr <= '0;
					if (check_en)
						state <= M_WR;
				end
				M_WR:
				begin
					addr <= addr + 1'b1;
					if (addr == mem_pkg::RAM_DEPTH - 1)
						state <= M_RW;
				end
				M_RW:
				begin
					chk_q <= 1'b1;
					exp_q <= pat;
					addr  <= addr + 1'b1;
					if (addr == mem_pkg::RAM_DEPTH - 1)
						state <= M_RD;
				end
				M_RD:
				begin
					chk_q <= 1'b1;
					exp_q <= ~pat;
					addr  <= addr + 1'b1;
					if (addr == mem_pkg::RAM_DEPTH - 1)
						state <= M_END;
				end
				M_END: state <= M_END;
				default: state <= M_IDLE;
			endcase
			// First mismatch aborts, M_END waits for the last compare
			if (chk_q && ram_rdata != exp_q)
			begin
				check_st.error <= 1'b1;
				chk_q          <= 1'b0;
				state          <= M_IDLE;
			end
			else if (state == M_END)
			begin
				check_st.done <= 1'b1;
				state         <= M_IDLE;
			end
		end
	end

endmodule

// ==== verilog/image_loader.sv ====
`timescale 1ns/1ps

module image_loader (
	input  logic                   sys_clk,
	input  logic                   glbl_rst_n,
	input  logic                   load_en,
	output mem_pkg::flash_req_t    flash_req,
	input  logic [31:0]            flash_rdata,
	output mem_pkg::ram_req_t      ram_req,
	output logic [7:0]             img_len,
	output init_pkg::step_status_t load_st
);

	typedef enum logic [2:0] {L_IDLE, L_HDR, L_HCHK, L_COPY, L_LAST} load_e;

	load_e                        state;
	logic [mem_pkg::FLASH_AW-1:0] rd_addr;
	logic [mem_pkg::RAM_AW-1:0]   wr_addr_q;
	logic                         wr_vld_q;
	mem_pkg::boot_word_u          hdr_w;

	assign hdr_w = flash_rdata;

	// Header read at word 0, then one image word per cycle
	always_comb
	begin
		flash_req = '0;
		if (state == L_HDR)
			flash_req.rd = 1'b1;
		else if (state == L_COPY)
		begin
			flash_req.rd   = 1'b1;
			flash_req.addr = rd_addr;
		end
	end

	// Returned flash word goes straight into RAM
	always_comb
	begin
		ram_req = '0;
		if (wr_vld_q)
		begin
			ram_req.we    = 1'b1;
			ram_req.addr  = wr_addr_q;
			ram_req.wdata = flash_rdata;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state    <= L_IDLE;
			rd_addr  <= '0;
			wr_vld_q <= 1'b0;
			img_len  <= '0;
			load_st  <= '0;
		end
		else
		begin
			load_st  <= '0;
			wr_vld_q <= 1'b0;
			case (state)
				L_IDLE: if (load_en) state <= L_HDR;
				L_HDR: state <= L_HCHK;
				L_HCHK:
				begin
					if (hdr_w.hdr.magic != mem_pkg::IMG_MAGIC || hdr_w.hdr.img_len == 8'd0 ||
						hdr_w.hdr.img_len > mem_pkg::RAM_DEPTH - 1)
					begin
						load_st.error <= 1'b1;
						state         <= L_IDLE;
					end
					else
					begin
						img_len <= hdr_w.hdr.img_len;
						rd_addr <= 8'd1;
						state   <= L_COPY;
					end
				end
				L_COPY:
				begin
					// Flash word n lands at RAM n-1, CRC word last
					wr_vld_q  <= 1'b1;
					wr_addr_q <= rd_addr[mem_pkg::RAM_AW-1:0] - 1'b1;
					rd_addr   <= rd_addr + 1'b1;
					if (rd_addr == img_len + 8'd1)
						state <= L_LAST;
				end
				L_LAST:
				begin
					load_st.done <= 1'b1;
					state        <= L_IDLE;
				end
				default: state <= L_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/crc32_checker.sv ====
`timescale 1ns/1ps

module crc32_checker (
	input  logic                   sys_clk,
	input  logic                   glbl_rst_n,
	input  logic                   comp_en,
	input  logic [7:0]             img_len,
	output mem_pkg::ram_req_t      ram_req,
	input  logic [31:0]            ram_rdata,
	output init_pkg::step_status_t comp_st
);

	typedef enum logic [1:0] {C_IDLE, C_RUN, C_WAIT} crc_e;

	crc_e                       state;
	logic [mem_pkg::RAM_AW-1:0] addr;
	logic                       vld_q;
	logic                       last_q;
	logic [31:0]                crc;

	// Bit 0 first, which is LSB byte first with each byte LSB first
	function automatic logic [31:0] crc32_word(input logic [31:0] c_in, input logic [31:0] d);
		logic [31:0] c;
		c = c_in;
		for (int i = 0; i < 32; i++)
			c = (c[0] ^ d[i]) ? ((c >> 1) ^ mem_pkg::CRC_POLY) : (c >> 1);
		return c;
	endfunction

	always_comb
	begin
		ram_req = '0;
		if (state == C_RUN)
		begin
			ram_req.re   = 1'b1;
			ram_req.addr = addr;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state   <= C_IDLE;
			addr    <= '0;
			vld_q   <= 1'b0;
			last_q  <= 1'b0;
			comp_st <= '0;
		end
		else
		begin
			comp_st <= '0;
			vld_q   <= 1'b0;
			case (state)
				C_IDLE:
				begin
					addr <= '0;
					crc  <= '1;
					if (comp_en)
						state <= C_RUN;
				end
				C_RUN:
				begin
					// Word img_len holds the stored CRC
					vld_q  <= 1'b1;
					last_q <= (8'(addr) == img_len);
					addr   <= addr + 1'b1;
					if (8'(addr) == img_len)
						state <= C_WAIT;
				end
				C_WAIT: state <= C_WAIT;
				default: state <= C_IDLE;
			endcase
			if (vld_q && !last_q)
				crc <= crc32_word(crc, ram_rdata);
			if (vld_q && last_q)
			begin
				if (ram_rdata == ~crc)
					comp_st.done <= 1'b1;
				else
					comp_st.error <= 1'b1;
				state <= C_IDLE;
			end
		end
	end

endmodule

// ==== verilog/id_reader.sv ====
`timescale 1ns/1ps

module id_reader (
	input  logic                   sys_clk,
	input  logic                   glbl_rst_n,
	input  logic                   id_en,
	output mem_pkg::flash_req_t    flash_req,
	input  logic [31:0]            flash_rdata,
	output mem_pkg::boot_word_u    id_word,
	output init_pkg::step_status_t id_st
);

	typedef enum logic [1:0] {I_IDLE, I_RD, I_CHK} id_e;

	id_e                 state;
	mem_pkg::boot_word_u rd_w;

	assign rd_w = flash_rdata;

	always_comb
	begin
		flash_req = '0;
		if (state == I_RD)
		begin
			flash_req.rd   = 1'b1;
			flash_req.addr = mem_pkg::ID_ADDR;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state <= I_IDLE;
			id_st <= '0;
		end
		else
		begin
			id_st <= '0;
			case (state)
				I_IDLE: if (id_en) state <= I_RD;
				I_RD: state <= I_CHK;
				I_CHK:
				begin
					// Word is kept even on a vendor mismatch
					id_word.raw <= flash_rdata;
					if (rd_w.ident.vendor != mem_pkg::VENDOR_ID)
						id_st.error <= 1'b1;
					else
						id_st.done <= 1'b1;
					state <= I_IDLE;
				end
				default: state <= I_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/mem_port_mux.sv ====
`timescale 1ns/1ps

module mem_port_mux (
	input  logic                sys_clk,
	input  logic                glbl_rst_n,
	input  mem_pkg::ram_req_t   march_ram,
	input  mem_pkg::ram_req_t   load_ram,
	input  mem_pkg::ram_req_t   crc_ram,
	input  mem_pkg::flash_req_t load_flash,
	input  mem_pkg::flash_req_t id_flash,
	output mem_pkg::ram_req_t   ram_req,
	output mem_pkg::flash_req_t flash_req
);

	// RAM owner 0 march, 1 loader, 2 CRC; flash owner 0 loader, 1 ID
	logic [1:0] ram_sel;
	logic [1:0] ram_sel_q;
	logic       flash_sel;
	logic       flash_sel_q;
	logic       ram_act;
	logic       flash_act;

	always_comb
	begin
		ram_act = march_ram.we | march_ram.re | load_ram.we | load_ram.re |
			crc_ram.we | crc_ram.re;
		if (march_ram.we | march_ram.re)
			ram_sel = 2'd0;
		else if (load_ram.we | load_ram.re)
			ram_sel = 2'd1;
		else if (crc_ram.we | crc_ram.re)
			ram_sel = 2'd2;
		else
			ram_sel = ram_sel_q;
		case (ram_sel)
			2'd0:    ram_req = march_ram;
			2'd1:    ram_req = load_ram;
			default: ram_req = crc_ram;
		endcase
		// No strobe means nothing reaches the RAM
		if (!ram_act)
			ram_req = '0;
	end

	always_comb
	begin
		flash_act = load_flash.rd | id_flash.rd;
		if (load_flash.rd)
			flash_sel = 1'b0;
		else if (id_flash.rd)
			flash_sel = 1'b1;
		else
			flash_sel = flash_sel_q;
		flash_req = flash_sel ? id_flash : load_flash;
		if (!flash_act)
			flash_req = '0;
	end

	// Owner of the last access, held while its read data returns
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			ram_sel_q   <= 2'd0;
			flash_sel_q <= 1'b0;
		end
		else
		begin
			ram_sel_q   <= ram_sel;
			flash_sel_q <= flash_sel;
		end
	end

endmodule

// ==== verilog/boot_init_top.sv ====
`timescale 1ns/1ps

module boot_init_top (
	input  logic                   sys_clk,
	input  logic                   glbl_rst_n,
	input  logic                   init_start,
	output logic                   init_ok,
	output logic                   init_fail,
	output init_pkg::init_status_t init_status,
	output mem_pkg::flash_req_t    flash_req,
	input  logic [31:0]            flash_rdata,
	output mem_pkg::ram_req_t      ram_req,
	input  logic [31:0]            ram_rdata
);

	logic                   check_en;
	logic                   load_en;
	logic                   comp_en;
	logic                   id_en;
	init_pkg::step_status_t check_st;
	init_pkg::step_status_t load_st;
	init_pkg::step_status_t comp_st;
	init_pkg::step_status_t id_st;
	logic [7:0]             img_len;
	mem_pkg::boot_word_u    id_word;
	mem_pkg::ram_req_t      march_ram;
	mem_pkg::ram_req_t      load_ram;
	mem_pkg::ram_req_t      crc_ram;
	mem_pkg::flash_req_t    load_flash;
	mem_pkg::flash_req_t    id_flash;

	init_sequencer u_seq (
		.sys_clk(sys_clk), .glbl_rst_n(glbl_rst_n), .init_start(init_start),
		.check_st(check_st), .load_st(load_st), .comp_st(comp_st), .id_st(id_st),
		.img_len(img_len), .id_word(id_word),
		.check_en(check_en), .load_en(load_en), .comp_en(comp_en), .id_en(id_en),
		.init_ok(init_ok), .init_fail(init_fail), .init_status(init_status)
	);

	////////////////////////////////////////////////////////////////////////////
	// Init steps
	////////////////////////////////////////////////////////////////////////////

	ram_march_checker u_march (
		.sys_clk(sys_clk), .glbl_rst_n(glbl_rst_n), .check_en(check_en),
		.ram_req(march_ram), .ram_rdata(ram_rdata), .check_st(check_st)
	);

	image_loader u_load (
		.sys_clk(sys_clk), .glbl_rst_n(glbl_rst_n), .load_en(load_en),
		.flash_req(load_flash), .flash_rdata(flash_rdata), .ram_req(load_ram),
		.img_len(img_len), .load_st(load_st)
	);

	crc32_checker u_crc (
		.sys_clk(sys_clk), .glbl_rst_n(glbl_rst_n), .comp_en(comp_en),
		.img_len(img_len), .ram_req(crc_ram), .ram_rdata(ram_rdata), .comp_st(comp_st)
	);

	id_reader u_id (
		.sys_clk(sys_clk), .glbl_rst_n(glbl_rst_n), .id_en(id_en),
		.flash_req(id_flash), .flash_rdata(flash_rdata), .id_word(id_word), .id_st(id_st)
	);

	// Single RAM and flash port shared by all steps
	mem_port_mux u_mux (
		.sys_clk(sys_clk), .glbl_rst_n(glbl_rst_n),
		.march_ram(march_ram), .load_ram(load_ram), .crc_ram(crc_ram),
		.load_flash(load_flash), .id_flash(id_flash),
		.ram_req(ram_req), .flash_req(flash_req)
	);

endmodule

// ==== bench/boot_init_tb.sv ====
`timescale 1ns/1ps

module boot_init_tb;

	localparam int          TIMEOUT_CYC = 5000;
	localparam int          QUIET_CYC   = 20;
	localparam logic [31:0] POLY        = 32'hEDB88320;

	// One scenario row with its expected outcome
	typedef struct packed {
		logic [7:0]       img_len;
		logic [15:0]      magic;
		logic [15:0]      vendor;
		logic [15:0]      dev;
		logic             crc_bad;
		logic             fault_en;
		logic [5:0]       fault_addr;
		logic [4:0]       fault_bit;
		logic             restart;
		logic             exp_ok;
		init_pkg::stage_e exp_stage;
	} scen_t;

	logic                   sys_clk = 1'b0;
	logic                   glbl_rst_n;
	logic                   init_start;
	logic                   init_ok;
	logic                   init_fail;
	init_pkg::init_status_t init_status;
	mem_pkg::flash_req_t    flash_req;
	logic [31:0]            flash_rdata = '0;
	mem_pkg::ram_req_t      ram_req;
	logic [31:0]            ram_rdata = '0;

	logic [31:0] flash_mem [0:255];
	logic [31:0] ram_mem [0:63];
	logic        fault_on;
	logic [5:0]  fault_addr;
	logic [4:0]  fault_bit;

	scen_t  rows[$];
	string  names[$];
	integer seed;
	int     errors;
	int     mon_errors = 0;
	int     ok_total = 0;
	int     fail_total = 0;
	logic   ok_q = 1'b0;
	logic   fail_q = 1'b0;
	bit     timed_out;

	always #4 sys_clk = ~sys_clk;

	boot_init_top u_dut (
		.sys_clk(sys_clk), .glbl_rst_n(glbl_rst_n), .init_start(init_start),
		.init_ok(init_ok), .init_fail(init_fail), .init_status(init_status),
		.flash_req(flash_req), .flash_rdata(flash_rdata),
		.ram_req(ram_req), .ram_rdata(ram_rdata)
	);

	// Byte-wise reflected CRC-32 step
	function automatic logic [31:0] crc_byte(input logic [31:0] c_in, input logic [7:0] b);
		logic [31:0] c;
		c = c_in ^ {24'd0, b};
		for (int k = 0; k < 8; k++)
			c = c[0] ? ((c >> 1) ^ POLY) : (c >> 1);
		return c;
	endfunction

	// Word fed low byte first
	function automatic logic [31:0] crc_word(input logic [31:0] c_in, input logic [31:0] w);
		logic [31:0] c;
		c = c_in;
		for (int b = 0; b < 4; b++)
			c = crc_byte(c, w[8*b +: 8]);
		return c;
	endfunction

	function automatic logic [31:0] stuck_mask(input logic [5:0] addr);
		return (fault_on && addr == fault_addr) ? (32'd1 << fault_bit) : 32'd0;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Memory models with one cycle read latency
	////////////////////////////////////////////////////////////////////////////

	always @(posedge sys_clk)
	begin : flash_model
		logic [31:0] rd_word;
		logic        rd_en;
		rd_en   = flash_req.rd;
		rd_word = flash_mem[flash_req.addr];
		#1;
		if (rd_en)
			flash_rdata = rd_word;
	end

	always @(posedge sys_clk)
	begin : ram_model
		logic [31:0] rd_word;
		logic        rd_en;
		// Old word is read before a same-cycle write
		rd_en   = ram_req.re;
		rd_word = ram_mem[ram_req.addr] & ~stuck_mask(ram_req.addr);
		if (!glbl_rst_n)
		begin
			for (int a = 0; a < 64; a++)
				ram_mem[a] = {8'(a) ^ 8'hC3, 8'(a), 16'hBEEF};
		end
		else if (ram_req.we)
			ram_mem[ram_req.addr] = ram_req.wdata & ~stuck_mask(ram_req.addr);
		#1;
		if (rd_en)
			ram_rdata = rd_word;
	end

	// Result pulse counter and width check
	always @(negedge sys_clk)
	begin
		if (glbl_rst_n)
		begin
			if (init_ok)
				ok_total++;
			if (init_fail)
				fail_total++;
			if ((init_ok && ok_q) || (init_fail && fail_q))
			begin
				$display("Result pulse stayed high for more than one cycle at %0t", $time);
				mon_errors++;
			end
			if (init_ok && init_fail)
			begin
				$display("init_ok and init_fail were high together at %0t", $time);
				mon_errors++;
			end
		end
		ok_q   <= init_ok;
		fail_q <= init_fail;
	end

	task automatic add_row(input string n, input logic [7:0] len, input logic [15:0] magic,
		input logic [15:0] vendor, input logic [15:0] dev, input logic crc_bad,
		input logic fault_en, input logic [5:0] faddr, input logic [4:0] fbit,
		input logic restart, input logic exp_ok, input init_pkg::stage_e stg);
		scen_t r;
		r.img_len    = len;
		r.magic      = magic;
		r.vendor     = vendor;
		r.dev        = dev;
		r.crc_bad    = crc_bad;
		r.fault_en   = fault_en;
		r.fault_addr = faddr;
		r.fault_bit  = fbit;
		r.restart    = restart;
		r.exp_ok     = exp_ok;
		r.exp_stage  = stg;
		rows.push_back(r);
		names.push_back(n);
	endtask

	task automatic build_table();
		//      name          len magic   vendor  dev   crc flt adr bit rst ok stage
		add_row("good_len8",    8, 'hB007, 'h1A5C, 'h0C01, 0, 0,  0, 0, 0, 1, init_pkg::STG_IDLE);
		add_row("good_len63",  63, 'hB007, 'h1A5C, 'h0C02, 0, 0,  0, 0, 1, 1, init_pkg::STG_IDLE);
		add_row("ram_stuck",    8, 'hB007, 'h1A5C, 'h0C03, 0, 1, 17, 2, 0, 0, init_pkg::STG_CHECK);
		add_row("bad_magic",    8, 'hB00F, 'h1A5C, 'h0C04, 0, 0,  0, 0, 0, 0, init_pkg::STG_LOAD);
		add_row("zero_len",     0, 'hB007, 'h1A5C, 'h0C05, 0, 0,  0, 0, 0, 0, init_pkg::STG_LOAD);
		add_row("crc_flip",    12, 'hB007, 'h1A5C, 'h0C06, 1, 0,  0, 0, 0, 0, init_pkg::STG_COMP);
		add_row("bad_vendor",   8, 'hB007, 'h1A5D, 'h0C07, 0, 0,  0, 0, 0, 0, init_pkg::STG_RD_ID);
	endtask

	// Known CRC-32 of the ASCII digits 1 to 9
	task automatic check_crc_ref();
		logic [31:0] c;
		c = 32'hFFFFFFFF;
		for (int k = 0; k < 9; k++)
			c = crc_byte(c, 8'h31 + 8'(k));
		if (~c != 32'hCBF43926)
		begin
			$display("ERROR crc_ref: expected %h actual %h", 32'hCBF43926, ~c);
			errors++;
		end
	endtask

	// Header, random image, CRC word and ID word
	task automatic load_flash(input scen_t r);
		logic [31:0] crc;
		for (int a = 0; a < 256; a++)
			flash_mem[a] = {8'(a), ~8'(a), 8'(a) ^ 8'h5A, 8'hF1};
		flash_mem[0] = {r.magic, r.img_len, 8'h00};
		crc = 32'hFFFFFFFF;
		for (int w = 1; w <= r.img_len; w++)
		begin
			flash_mem[w] = $random(seed);
			crc = crc_word(crc, flash_mem[w]);
		end
		crc = ~crc;
		if (r.crc_bad)
			crc = crc ^ 32'h00000400;
		flash_mem[r.img_len + 1] = crc;
		flash_mem[255] = {r.vendor, r.dev};
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One scenario run
	////////////////////////////////////////////////////////////////////////////

	task automatic run_row(input int idx, output bit to);
		scen_t r;
		int    cycles;
		int    ok_base;
		int    fail_base;
		r  = rows[idx];
		to = 1'b0;
		load_flash(r);
		fault_on   = r.fault_en;
		fault_addr = r.fault_addr;
		fault_bit  = r.fault_bit;
		ok_base    = ok_total;
		fail_base  = fail_total;
		@(posedge sys_clk);
		#1 init_start = 1'b1;
		@(posedge sys_clk);
		#1 init_start = 1'b0;
		cycles = 0;
		while (!init_ok && !init_fail && cycles < TIMEOUT_CYC)
		begin
			@(posedge sys_clk);
			#1;
			// Start held high from mid-run until the result
			init_start = r.restart && cycles >= 40;
			cycles++;
		end
		init_start = 1'b0;
		if (!init_ok && !init_fail)
		begin
			$display("Row %s: no init_ok or init_fail within %0d cycles", names[idx],
				TIMEOUT_CYC);
			to = 1'b1;
		end
		else
		begin
			if (init_ok !== r.exp_ok)
			begin
				$display("ERROR %s: init_ok expected %b actual %b", names[idx], r.exp_ok,
					init_ok);
				errors++;
			end
			if (init_status.fail_stage !== r.exp_stage)
			begin
				$display("ERROR %s: fail_stage expected %0d actual %0d", names[idx],
					r.exp_stage, init_status.fail_stage);
				errors++;
			end
			if (r.exp_ok)
			begin
				if (init_status.img_len !== r.img_len)
				begin
					$display("ERROR %s: img_len expected %0d actual %0d", names[idx],
						r.img_len, init_status.img_len);
					errors++;
				end
				if (init_status.dev_id !== r.dev)
				begin
					$display("ERROR %s: dev_id expected %h actual %h", names[idx], r.dev,
						init_status.dev_id);
					errors++;
				end
				if (init_status.vendor_id !== r.vendor)
				begin
					$display("ERROR %s: vendor_id expected %h actual %h", names[idx],
						r.vendor, init_status.vendor_id);
					errors++;
				end
				for (int w = 0; w <= r.img_len; w++)
					if (ram_mem[w] !== flash_mem[w + 1])
					begin
						$display("ERROR %s: RAM word %0d expected %h actual %h", names[idx],
							w, flash_mem[w + 1], ram_mem[w]);
						errors++;
					end
			end
			// No further result pulse may follow
			repeat (QUIET_CYC) @(posedge sys_clk);
			if (ok_total - ok_base != (r.exp_ok ? 1 : 0))
			begin
				$display("ERROR %s: init_ok pulses expected %0d actual %0d", names[idx],
					r.exp_ok ? 1 : 0, ok_total - ok_base);
				errors++;
			end
			if (fail_total - fail_base != (r.exp_ok ? 0 : 1))
			begin
				$display("ERROR %s: init_fail pulses expected %0d actual %0d", names[idx],
					r.exp_ok ? 0 : 1, fail_total - fail_base);
				errors++;
			end
		end
	endtask

	initial
	begin
		seed       = 35;
		errors     = 0;
		timed_out  = 1'b0;
		glbl_rst_n = 1'b0;
		init_start = 1'b0;
		fault_on   = 1'b0;
		fault_addr = '0;
		fault_bit  = '0;
		build_table();
		check_crc_ref();
		repeat (3) @(posedge sys_clk);
		#1 glbl_rst_n = 1'b1;
		if ({init_ok, init_fail, flash_req.rd, ram_req.we, ram_req.re} !== 5'b0)
		begin
			$display("ERROR reset_idle: strobes expected %b actual %b", 5'b0,
				{init_ok, init_fail, flash_req.rd, ram_req.we, ram_req.re});
			errors++;
		end
		for (int i = 0; i < rows.size() && !timed_out; i++)
			run_row(i, timed_out);
		$display("Errors: %0d total, %0d from checks, %0d from pulse monitor",
			errors + mon_errors, errors, mon_errors);
		if (timed_out || errors + mon_errors != 0)
			$display("Simulation finished: FAIL");
		else
			$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== boot_init.f ====
verilog/init_pkg.sv
verilog/mem_pkg.sv
verilog/init_sequencer.sv
verilog/ram_march_checker.sv
verilog/image_loader.sv
verilog/crc32_checker.sv
verilog/id_reader.sv
verilog/mem_port_mux.sv
verilog/boot_init_top.sv
bench/boot_init_tb.sv

// ==== Makefile ====
TOP = boot_init_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f boot_init.f \
		-Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module boot_init_top -f boot_init.f

clean:
	rm -rf obj_dir $(LOG)
